// ==== build.f ====
cpu_pkg.sv
program_memory.sv
mem_arbiter.sv
fetch_unit.sv
exec_unit.sv
cpu_top.sv
tb_clock.sv
tb_cpu.sv

// ==== cpu_pkg.sv ====
// Shared types for the eight-bit accumulator CPU: data, address, opcodes and FSM states.
package cpu_pkg;

	typedef logic [7:0] word_t;	// One data byte.
	typedef logic [7:0] addr_t;	// One memory address.

	// Instruction set, one byte per opcode.
	typedef enum logic [7:0] {
		op_nop = 8'h00,
		op_ldx = 8'h01, op_lix = 8'h02, op_stx = 8'h03,	// X register.
		op_ldy = 8'h09, op_liy = 8'h0a, op_sty = 8'h0b,	// Y register.
		op_ldz = 8'h11, op_liz = 8'h12, op_stz = 8'h13,	// Z register.
		op_inz = 8'h15, op_dez = 8'h16, op_clz = 8'h17,	// Z count ops.
		op_lda = 8'h19, op_lia = 8'h1a, op_sta = 8'h1b,	// Accumulator.
		op_cla = 8'h1c,					// Clears acc and both flags.
		op_adx = 8'h21, op_ady = 8'h22, op_adz = 8'h23,	// Add register.
		op_add = 8'h24, op_adi = 8'h25,			// Add memory, immediate.
		op_sux = 8'h26, op_suy = 8'h27, op_suz = 8'h28,	// Subtract register.
		op_sub = 8'h29, op_sui = 8'h2a,			// Subtract memory, immediate.
		op_lsl = 8'h36, op_lsr = 8'h37,			// Shifts through carry.
		op_rol = 8'h38, op_ror = 8'h39,			// Rotates through carry.
		op_jmp = 8'h41, op_jzs = 8'h42, op_jzc = 8'h43,	// Jumps.
		op_jcs = 8'h44, op_jcc = 8'h45,
		op_jsr = 8'h46, op_rsr = 8'h47,			// Single-level call.
		op_txa = 8'h51, op_tax = 8'h52,			// Transfers.
		op_tya = 8'h53, op_tay = 8'h54,
		op_tza = 8'h55, op_taz = 8'h56,
		op_cmp = 8'h61, op_cmi = 8'h62,			// Compares, acc unchanged.
		op_cpx = 8'h63, op_cpy = 8'h64, op_cpz = 8'h65,
		op_clc = 8'h66,
		op_clo = 8'h81, op_otx = 8'h82, op_oty = 8'h83,	// Output port.
		op_otz = 8'h84, op_ota = 8'h85,
		op_hlt = 8'hff
	} opcode_e;

	// Execute unit steps.
	typedef enum logic [2:0] {
		st_idle,	// Waiting for an instruction.
		st_decode,	// Classify, raise data request.
		st_data_wait,	// Data access in flight.
		st_update,	// Write results, pulse done.
		st_halted	// Stopped until reset.
	} exec_state_e;

	// Memory requesters, highest priority first.
	typedef enum logic [1:0] {
		req_load,
		req_exec,
		req_fetch
	} req_id_e;

endpackage

// ==== cpu_testdata.hex ====
// Program words: high byte is the address, low byte the data, FFFF ends the program.
// Expected port_out values follow as 00vv words, closed by another FFFF.
0002 0111 0282 0351 0454 051A 0622 0756   // LIX 11, OTX, TXA, TAY, LIA 22, TAZ
0883 0984 0A15 0B84                       // OTY, OTZ, INZ, OTZ
0C1A 0DF0 0E25 0F20 1044 1114 1281 13FF   // F0 + 20 carries out, JCS taken
1485 152A 1610 1742 181B 1981 1AFF        // OTA 10, SUI to zero, JZS taken
1B2A 1C01 1D45 1E21 1F85 2066             // Borrow, JCC not taken, OTA FF, CLC
211A 2240 2302 2430 2521 2685             // 40 + X 30, OTA 70
2763 2844 292C 2A62 2B70                  // CPX clears carry, CMI 70 sets both
2C42 2D31 2E83 2F81 30FF 3126 3285        // JZS taken, SUX, OTA 40
331A 345A 351B 36E0 370A 3807 390B 3AE1   // Store 5A at E0 and 07 at E1
3B1C 3C01 3DE0 3E82                       // CLA, LDX E0, OTX
3F19 40E1 4124 42E0 4385                  // LDA E1, ADD E0, OTA 61
4429 45E1 4685 4711 48E1 4984             // SUB E1, OTA 5A, LDZ E1, OTZ
4A61 4BE0 4C43 4D50 4E46 4F60             // CMP E0 equal, JZC not taken, JSR 60
500A 5199 5283 5344 5457 5581 56FF 57FF   // Return point, LIY 99, OTY, JCS to HLT
5881                                      // Never reached
601A 6181 6236 6338 6485 6539 6639 6785   // LIA 81, LSL, ROL, OTA, ROR, ROR, OTA
6837 6985 6A47                            // LSR, OTA, RSR
FFFF
0011 0011 0022 0023 0010 00FF 0070 0040
005A 0061 005A 0007 0005 0081 0040 0099
FFFF

// ==== cpu_top.sv ====
// Top level of the accumulator CPU, wiring fetch, execute, arbiter and memory.
`timescale 1ns/1ps

module cpu_top #(
	parameter int MEM_DEPTH = 256
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            run,
	input  logic            load_we,
	input  cpu_pkg::addr_t  load_addr,
	input  cpu_pkg::word_t  load_data,
	output cpu_pkg::word_t  port_out,
	output logic            port_strobe,
	output logic            halted
);
	import cpu_pkg::*;

	logic    fetch_req, fetch_gnt, fetch_rvalid;
	addr_t   fetch_addr;
	logic    exec_req, exec_we, exec_gnt, exec_rvalid;
	addr_t   exec_addr;
	word_t   exec_wdata;
	logic    mem_we;
	addr_t   mem_addr;
	word_t   mem_wdata, mem_rdata;
	word_t   rdata;	// Arbiter return bus.
	logic    instr_valid, done, redirect, call, ret;
	opcode_e opcode;
	word_t   operand;
	addr_t   target;

	program_memory #(
		.MEM_DEPTH(MEM_DEPTH)
	) i_mem (
		.clk(clk), .we(mem_we), .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
	);

	mem_arbiter i_arb (
		.clk(clk), .rst(rst),
		.load_req(load_we), .load_addr(load_addr), .load_data(load_data),
		.exec_req(exec_req), .exec_we(exec_we), .exec_addr(exec_addr),
		.exec_wdata(exec_wdata),
		.fetch_req(fetch_req), .fetch_addr(fetch_addr),
		.mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
		.exec_gnt(exec_gnt), .fetch_gnt(fetch_gnt),
		.exec_rvalid(exec_rvalid), .fetch_rvalid(fetch_rvalid), .rdata(rdata)
	);

	fetch_unit i_fetch (
		.clk(clk), .rst(rst), .run(run),
		.req(fetch_req), .addr(fetch_addr), .gnt(fetch_gnt), .rvalid(fetch_rvalid),
		.rdata(rdata),
		.instr_valid(instr_valid), .opcode(opcode), .operand(operand),
		.done(done), .redirect(redirect), .call(call), .ret(ret), .target(target)
	);

	exec_unit i_exec (
		.clk(clk), .rst(rst),
		.instr_valid(instr_valid), .opcode(opcode), .operand(operand),
		.done(done), .redirect(redirect), .call(call), .ret(ret), .target(target),
		.req(exec_req), .we(exec_we), .addr(exec_addr), .wdata(exec_wdata),
		.gnt(exec_gnt), .rvalid(exec_rvalid), .rdata(rdata),
		.port_out(port_out), .port_strobe(port_strobe), .halted(halted)
	);

endmodule

// ==== exec_unit.sv ====
// Execute unit with registers, accumulator, flags, data accesses and output port.
`timescale 1ns/1ps

module exec_unit (
	input  logic              clk,
	input  logic              rst,
	input  logic              instr_valid,
	input  cpu_pkg::opcode_e  opcode,
	input  cpu_pkg::word_t    operand,
	output logic              done,
	output logic              redirect,
	output logic              call,
	output logic              ret,
	output cpu_pkg::addr_t    target,
	output logic              req,
	output logic              we,
	output cpu_pkg::addr_t    addr,
	output cpu_pkg::word_t    wdata,
	input  logic              gnt,
	input  logic              rvalid,
	input  cpu_pkg::word_t    rdata,
	output cpu_pkg::word_t    port_out,
	output logic              port_strobe,
	output logic              halted
);
	import cpu_pkg::*;

	localparam int CF = 1;	// Carry flag bit.
	localparam int ZF = 0;	// Zero flag bit.

	exec_state_e state_q;
	opcode_e     op_q;
	word_t       arg_q;
	word_t       mem_q;	// Byte read from memory.
	word_t       x_q, y_q, z_q, acc_q;
	logic [1:0]  flags_q;
	logic        req_q, done_q, strobe_q;
	word_t       port_q;
	logic        mem_op, store_op, take;
	word_t       src;	// Selected source operand.
	word_t       alu_res;
	logic        alu_c;
	logic [8:0]  sum9, diff9;

	always_comb begin
		mem_op   = 1'b0;
		store_op = 1'b0;
		case (op_q)
			op_ldx, op_ldy, op_ldz, op_lda, op_add, op_sub, op_cmp: mem_op = 1'b1;
			op_stx, op_sty, op_stz, op_sta: begin
				mem_op   = 1'b1;
				store_op = 1'b1;
			end
			default: ;
		endcase
	end

	always_comb begin
		case (op_q)
			op_adx, op_sux, op_cpx, op_txa, op_otx, op_stx: src = x_q;
			op_ady, op_suy, op_cpy, op_tya, op_oty, op_sty: src = y_q;
			op_adz, op_suz, op_cpz, op_tza, op_otz, op_stz: src = z_q;
			op_tax, op_tay, op_taz, op_ota, op_sta: src = acc_q;
			op_ldx, op_ldy, op_ldz, op_lda, op_add, op_sub, op_cmp: src = mem_q;
			default: src = arg_q;	// Immediates.
		endcase
	end

	assign sum9  = {1'b0, acc_q} + {1'b0, src};
	assign diff9 = {1'b0, acc_q} - {1'b0, src};	// Top bit is borrow.

	always_comb begin
		{alu_c, alu_res} = sum9;
		case (op_q)
			op_sux, op_suy, op_suz, op_sub, op_sui: {alu_c, alu_res} = diff9;
			op_lsl: {alu_c, alu_res} = {acc_q, 1'b0};
			op_rol: {alu_c, alu_res} = {acc_q, flags_q[CF]};
			op_lsr: {alu_res, alu_c} = {1'b0, acc_q};
			op_ror: {alu_res, alu_c} = {flags_q[CF], acc_q};
			default: ;
		endcase
	end

	// Flags as they stand, jumps leave them alone.
	always_comb begin
		case (op_q)
			op_jmp, op_jsr: take = 1'b1;
			op_jzs: take = flags_q[ZF];
			op_jzc: take = !flags_q[ZF];
			op_jcs: take = flags_q[CF];
			op_jcc: take = !flags_q[CF];
			default: take = 1'b0;
		endcase
	end

	assign req         = req_q;
	assign we          = store_op;
	assign addr        = arg_q;	// Direct address.
	assign wdata       = src;
	assign done        = done_q;
	assign redirect    = done_q && take;
	assign call        = done_q && (op_q == op_jsr);
	assign ret         = done_q && (op_q == op_rsr);
	assign target      = arg_q;
	assign port_out    = port_q;
	assign port_strobe = strobe_q;
	assign halted      = (state_q == st_halted);

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q  <= st_idle;
			req_q    <= 1'b0;
			done_q   <= 1'b0;
			strobe_q <= 1'b0;
			port_q   <= '0;
			flags_q  <= '0;
			x_q      <= '0;
			y_q      <= '0;
			z_q      <= '0;
			acc_q    <= '0;
		end else begin
			done_q   <= 1'b0;
			strobe_q <= 1'b0;
			case (state_q)
				st_idle: begin
					if (instr_valid) begin
						state_q <= st_decode;
					end
				end
				st_decode: begin
					if (op_q == op_hlt) begin
						state_q <= st_halted;	// No done, fetch stays parked.
					end else if (mem_op) begin
						req_q   <= 1'b1;
						state_q <= st_data_wait;
					end else begin
						state_q <= st_update;
					end
				end
				st_data_wait: begin
					if (gnt) begin
						req_q <= 1'b0;
					end
					if ((gnt && store_op) || rvalid) begin
						state_q <= st_update;	// Write done or byte back.
					end
				end
				st_update: begin
					done_q  <= 1'b1;
					state_q <= st_idle;
					case (op_q)
						op_ldx, op_lix, op_tax: x_q <= src;
						op_ldy, op_liy, op_tay: y_q <= src;
						op_ldz, op_liz, op_taz: z_q <= src;
						op_inz: z_q <= z_q + 8'd1;
						op_dez: z_q <= z_q - 8'd1;
						op_clz: z_q <= '0;
						op_lda, op_lia, op_txa, op_tya, op_tza: acc_q <= src;
						op_cla: begin
							acc_q   <= '0;
							flags_q <= '0;
						end
						op_adx, op_ady, op_adz, op_add, op_adi,
						op_sux, op_suy, op_suz, op_sub, op_sui,
						op_lsl, op_lsr, op_rol, op_ror: begin
							acc_q       <= alu_res;
							flags_q[CF] <= alu_c;
							flags_q[ZF] <= (alu_res == '0);
						end
						op_cmp, op_cmi, op_cpx, op_cpy, op_cpz: begin
							flags_q[CF] <= (src >= acc_q);	// Operand at least acc.
							flags_q[ZF] <= (src == acc_q);
						end
						op_clc: flags_q[CF] <= 1'b0;
						op_clo: begin
							port_q   <= '0;
							strobe_q <= 1'b1;
						end
						op_otx, op_oty, op_otz, op_ota: begin
							port_q   <= src;
							strobe_q <= 1'b1;
						end
						default: ;	// Stores, jumps, nop.
					endcase
				end
				st_halted: ;	// Held until reset.
				default: state_q <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == st_idle && instr_valid) begin
			op_q  <= opcode;
			arg_q <= operand;
		end
		if (rvalid) begin
			mem_q <= rdata;
		end
	end

	// Halt is final and silent.
	a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
		halted |-> !port_strobe ##1 halted);

endmodule

// ==== fetch_unit.sv ====
// Fetch unit with program counter, return address and opcode/operand fetch.
`timescale 1ns/1ps

module fetch_unit (
	input  logic              clk,
	input  logic              rst,
	input  logic              run,
	output logic              req,
	output cpu_pkg::addr_t    addr,
	input  logic              gnt,
	input  logic              rvalid,
	input  cpu_pkg::word_t    rdata,
	output logic              instr_valid,
	output cpu_pkg::opcode_e  opcode,
	output cpu_pkg::word_t    operand,
	input  logic              done,
	input  logic              redirect,
	input  logic              call,
	input  logic              ret,
	input  cpu_pkg::addr_t    target
);
	import cpu_pkg::*;

	typedef enum logic [2:0] {
		fs_stop,	// Waiting for run.
		fs_op,		// Requesting opcode byte.
		fs_op_wait,
		fs_arg,		// Requesting operand byte.
		fs_arg_wait,
		fs_busy		// Instruction in exec.
	} fetch_state_e;

	fetch_state_e state_q;
	addr_t        pc_q;
	addr_t        ret_addr_q;	// Single-level return.
	logic         instr_valid_q;
	opcode_e      opcode_q;
	word_t        operand_q;

	// Instructions that carry an operand byte.
	function automatic logic two_byte(opcode_e op);
		case (op)
			op_ldx, op_lix, op_stx, op_ldy, op_liy, op_sty,
			op_ldz, op_liz, op_stz, op_lda, op_lia, op_sta,
			op_add, op_adi, op_sub, op_sui, op_cmp, op_cmi,
			op_jmp, op_jzs, op_jzc, op_jcs, op_jcc, op_jsr: two_byte = 1'b1;
			default: two_byte = 1'b0;
		endcase
	endfunction

	assign req         = (state_q == fs_op) || (state_q == fs_arg);
	assign addr        = pc_q;
	assign instr_valid = instr_valid_q;
	assign opcode      = opcode_q;
	assign operand     = operand_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q       <= fs_stop;
			pc_q          <= '0;
			ret_addr_q    <= '0;
			instr_valid_q <= 1'b0;
		end else begin
			instr_valid_q <= 1'b0;
			case (state_q)
				fs_stop: begin
					if (run) begin
						state_q <= fs_op;
					end
				end
				fs_op, fs_arg: begin
					if (gnt) begin
						pc_q    <= pc_q + 8'd1;	// Step past this byte.
						state_q <= (state_q == fs_op) ? fs_op_wait : fs_arg_wait;
					end
				end
				fs_op_wait: begin
					if (rvalid && two_byte(opcode_e'(rdata))) begin
						state_q <= fs_arg;
					end else if (rvalid) begin
						instr_valid_q <= 1'b1;
						state_q       <= fs_busy;
					end
				end
				fs_arg_wait: begin
					if (rvalid) begin
						instr_valid_q <= 1'b1;
						state_q       <= fs_busy;
					end
				end
				fs_busy: begin
					if (done) begin
						if (ret) begin
							pc_q <= ret_addr_q;
						end else if (redirect) begin
							pc_q <= target;	// Taken jump or call.
						end
						if (call) begin
							ret_addr_q <= pc_q;	// Already past operand.
						end
						state_q <= run ? fs_op : fs_stop;
					end
				end
				default: state_q <= fs_stop;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == fs_op_wait && rvalid) begin
			opcode_q  <= opcode_e'(rdata);
			operand_q <= '0;	// Zero for one-byte forms.
		end
		if (state_q == fs_arg_wait && rvalid) begin
			operand_q <= rdata;
		end
	end

	// One instruction in flight, so no new one before done.
	a_one_in_flight: assert property (@(posedge clk) disable iff (rst)
		instr_valid |=> !instr_valid until done);

endmodule

// ==== mem_arbiter.sv ====
// Fixed-priority memory arbiter for the load port, execute unit and fetch unit.
`timescale 1ns/1ps

module mem_arbiter (
	input  logic            clk,
	input  logic            rst,
	input  logic            load_req,
	input  cpu_pkg::addr_t  load_addr,
	input  cpu_pkg::word_t  load_data,
	input  logic            exec_req,
	input  logic            exec_we,
	input  cpu_pkg::addr_t  exec_addr,
	input  cpu_pkg::word_t  exec_wdata,
	input  logic            fetch_req,
	input  cpu_pkg::addr_t  fetch_addr,
	output logic            mem_we,
	output cpu_pkg::addr_t  mem_addr,
	output cpu_pkg::word_t  mem_wdata,
	input  cpu_pkg::word_t  mem_rdata,
	output logic            exec_gnt,
	output logic            fetch_gnt,
	output logic            exec_rvalid,
	output logic            fetch_rvalid,
	output cpu_pkg::word_t  rdata
);
	import cpu_pkg::*;

	req_id_e sel;		// Winner this cycle.
	logic    sel_read;	// Winner reads.
	req_id_e owner_q;	// Owner of last access.
	logic    pend_q;	// Read data due now.

	always_comb begin
		if (load_req) begin
			sel = req_load;	// Load always wins.
		end else if (exec_req) begin
			sel = req_exec;
		end else begin
			sel = req_fetch;	// Also the idle choice.
		end
	end

	always_comb begin
		case (sel)
			req_load: begin
				mem_we    = 1'b1;	// Load port is write only.
				mem_addr  = load_addr;
				mem_wdata = load_data;
			end
			req_exec: begin
				mem_we    = exec_we;
				mem_addr  = exec_addr;
				mem_wdata = exec_wdata;
			end
			default: begin
				mem_we    = 1'b0;	// Fetch only reads.
				mem_addr  = fetch_addr;
				mem_wdata = exec_wdata;
			end
		endcase
	end

	assign exec_gnt  = (sel == req_exec);
	assign fetch_gnt = (sel == req_fetch) && fetch_req;
	assign sel_read  = fetch_gnt || (exec_gnt && !exec_we);

	always_ff @(posedge clk) begin
		if (rst) begin
			pend_q  <= 1'b0;
			owner_q <= req_fetch;
		end else begin
			pend_q  <= sel_read;
			owner_q <= sel;	// Steers rvalid next cycle.
		end
	end

	assign exec_rvalid  = pend_q && (owner_q == req_exec);
	assign fetch_rvalid = pend_q && (owner_q == req_fetch);
	assign rdata        = mem_rdata;	// Shared return bus.

	a_one_grant: assert property (@(posedge clk) disable iff (rst)
		$onehot0({exec_gnt, fetch_gnt}));

endmodule

// ==== program_memory.sv ====
// Shared instruction and data memory, single port, synchronous read and write.
`timescale 1ns/1ps

module program_memory #(
	parameter int MEM_DEPTH = 256
) (
	input  logic            clk,
	input  logic            we,
	input  cpu_pkg::addr_t  addr,
	input  cpu_pkg::word_t  wdata,
	output cpu_pkg::word_t  rdata
);
	import cpu_pkg::*;

	word_t mem [MEM_DEPTH];	// Contents come from the load port.

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;	// Write in the grant cycle.
		end
		rdata <= mem[addr];	// Byte valid one cycle later.
	end

endmodule

// ==== run.sh ====
#!/bin/bash
# Builds the CPU testbench with Verilator, runs it and scans the log for failure.
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu -f build.f -o tb_cpu
./obj_dir/tb_cpu | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "Simulation reported errors, see sim.log"
	exit 1
fi
echo "Simulation finished without errors"

// ==== tb_clock.sv ====
// Testbench clock and reset source, free-running clock with reset held for the first cycles.
`timescale 1ns/1ps

module tb_clock #(
	parameter int HALF_PERIOD = 50,	// In ns, so 100 ns period.
	parameter int RST_CYCLES  = 10
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	initial begin
		rst = 1'b1;	// Active from time zero.
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;	// Released on a rising edge.
	end

endmodule

// ==== tb_cpu.sv ====
// Testbench for the accumulator CPU, loads a program and checks the output port sequence.
`timescale 1ns/1ps

module tb_cpu;
	import cpu_pkg::*;

	localparam int TDATA_WORDS     = 256;	// Room for program and expected list.
	localparam int RNG_SEED        = 78337;
	localparam int CYCLES_PER_BYTE = 40;
	localparam int TIMEOUT_MARGIN  = 500;
	localparam int HALT_SETTLE     = 20;	// Quiet cycles watched after halt.

	logic        clk, rst, run, load_we;
	addr_t       load_addr;
	word_t       load_data, port_out;
	logic        port_strobe, halted;
	logic [15:0] tdata [0:TDATA_WORDS-1];	// Raw words from the data file.
	int          prog_len  = 0;
	int          exp_first = 0;	// Index of first expected value.
	int          exp_len   = 0;
	int          seen      = 0;	// Strobes observed so far.
	int          errors    = 0;
	int          cycles    = 0;
	int          limit     = 0;	// Zero until the data is parsed.

	tb_clock #(
		.HALF_PERIOD(50),
		.RST_CYCLES(10)
	) i_clk (
		.clk(clk), .rst(rst)
	);

	cpu_top #(
		.MEM_DEPTH(256)
	) i_dut (
		.clk(clk), .rst(rst), .run(run),
		.load_we(load_we), .load_addr(load_addr), .load_data(load_data),
		.port_out(port_out), .port_strobe(port_strobe), .halted(halted)
	);

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			errors = errors + 1;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors = errors + 1;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// Writes every program word through the load port, random gaps between.
	task automatic load_program();
		int idle;
		for (int i = 0; i < prog_len; i++) begin
			idle = $urandom_range(3, 0);
			@(posedge clk);
			load_we   <= 1'b1;
			load_addr <= tdata[i][15:8];	// Address in high byte.
			load_data <= tdata[i][7:0];
			repeat (idle) begin
				@(posedge clk);
				load_we <= 1'b0;
			end
		end
		@(posedge clk);
		load_we <= 1'b0;
	endtask

	// Every strobe is matched against the next expected value.
	always @(negedge clk) begin
		if (!rst && port_strobe) begin
			if (halted) begin
				errors = errors + 1;
				$display("Output strobe seen while the CPU is halted");
			end else if (seen >= exp_len) begin
				errors = errors + 1;
				$display("More output strobes than expected values");
			end else begin
				check_word("port_out", port_out, tdata[exp_first + seen][7:0]);
			end
			seen = seen + 1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout: CPU did not halt within %0d cycles", limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		int idx;
		void'($urandom(RNG_SEED));
		run       = 1'b0;
		load_we   = 1'b0;
		load_addr = '0;
		load_data = '0;
		$readmemh("cpu_testdata.hex", tdata);
		idx = 0;
		while (idx < TDATA_WORDS && tdata[idx] !== 16'hffff) idx = idx + 1;
		prog_len  = idx;
		exp_first = idx + 1;	// Skip program end marker.
		idx       = exp_first;
		while (idx < TDATA_WORDS && tdata[idx] !== 16'hffff) idx = idx + 1;
		exp_len = idx - exp_first;
		if (idx >= TDATA_WORDS) begin
			errors = errors + 1;
			$display("Test data is missing an end marker");
		end
		limit = CYCLES_PER_BYTE * prog_len + TIMEOUT_MARGIN;

		@(negedge clk);
		while (rst) @(negedge clk);
		check_bit("halted", halted, 1'b0);	// Reset state.
		check_bit("port_strobe", port_strobe, 1'b0);
		check_word("port_out", port_out, 8'h00);

		load_program();
		@(posedge clk);
		run <= 1'b1;

		while (!halted) @(negedge clk);
		repeat (HALT_SETTLE) @(negedge clk);	// Halt must stay silent.
		check_bit("halted", halted, 1'b1);
		if (seen != exp_len) begin
			errors = errors + 1;
			$display("Saw %0d output strobes, expected %0d", seen, exp_len);
		end

		$display("Run ended: %0d strobes, %0d errors", seen, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
